// ==== common/hack_pkg.sv ====
package hack_pkg;

  //////////////////////////////////////////////////////////////////////
  // Words, addresses and memory size
  //////////////////////////////////////////////////////////////////////

  typedef logic [15:0] word_t;
  typedef logic [14:0] addr_t;

  // 32K words in each memory
  localparam int mem_depth = 32768;

  // One instruction word, read as A form or C form
  // Top bit picks the form: 0 for A, 1 for C
  typedef union packed {
    struct packed {
      logic        op;
      logic [14:0] value;
    } a_instr;
    struct packed {
      logic       op;
      logic [1:0] unused;
      // Selects M instead of A as the y operand
      logic       a;
      // zx nx zy ny f no
      logic [5:0] alu;
      // A D M
      logic [2:0] dest;
      // lt eq gt
      logic [2:0] jump;
    } c_instr;
  } hack_instr_t;

  //////////////////////////////////////////////////////////////////////
  // Boot image and SPI flash
  //////////////////////////////////////////////////////////////////////

  // Words in the program image
  localparam int boot_words = 16;

  localparam logic [23:0] flash_read_offset = 24'h100000;
  localparam logic [7:0]  flash_reset_cmd_1 = 8'h66;
  localparam logic [7:0]  flash_reset_cmd_2 = 8'h99;
  localparam logic [7:0]  flash_read_cmd    = 8'h03;

  // System clocks per SCK half period
  localparam int flash_half_period = 8;
  // Idle clocks with ssb high after the reset commands
  localparam int flash_reset_wait  = 400;

  // Loader phases
  localparam logic [2:0] ph_reset_1   = 3'd0;
  localparam logic [2:0] ph_reset_2   = 3'd1;
  localparam logic [2:0] ph_wait      = 3'd2;
  localparam logic [2:0] ph_read_cmd  = 3'd3;
  localparam logic [2:0] ph_read_data = 3'd4;
  localparam logic [2:0] ph_done      = 3'd5;

  // Loader frame states
  localparam logic [1:0] fr_select   = 2'd0;
  localparam logic [1:0] fr_shift    = 2'd1;
  localparam logic [1:0] fr_stop     = 2'd2;
  localparam logic [1:0] fr_unselect = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // Run loop and UART
  //////////////////////////////////////////////////////////////////////

  // Data address mirrored to the UART
  localparam addr_t tx_address = 15'd24577;

  // UART bit time in system clocks
  localparam int clocks_per_bit = 104;

  // Sequencer states
  localparam logic [3:0] sq_idle    = 4'd0;
  localparam logic [3:0] sq_fetch   = 4'd1;
  localparam logic [3:0] sq_operand = 4'd2;
  localparam logic [3:0] sq_instr   = 4'd3;
  localparam logic [3:0] sq_in_m    = 4'd4;
  localparam logic [3:0] sq_step    = 4'd5;
  localparam logic [3:0] sq_capture = 4'd6;
  localparam logic [3:0] sq_write   = 4'd7;
  localparam logic [3:0] sq_send    = 4'd8;
  localparam logic [3:0] sq_busy    = 4'd9;

endpackage

// ==== common/prog_mem_if.sv ====
interface prog_mem_if;
  import hack_pkg::*;

  // One requester's view of program memory
  addr_t addr;
  word_t wdata;
  logic  we;
  // Registered read data, one clock after addr
  word_t rdata;

  modport requester (
    output addr, wdata, we,
    input  rdata
  );

  modport arbiter (
    input  addr, wdata, we,
    output rdata
  );

endinterface

// ==== hw/word_ram.sv ====
module word_ram (
  input  logic            CLK,
  input  hack_pkg::addr_t addr,
  input  hack_pkg::word_t wdata,
  input  logic            we,
  output hack_pkg::word_t rdata
);
  import hack_pkg::*;

  word_t mem [mem_depth];

  // Single port, read returns the old contents on a write
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

// ==== hw/prog_mem_arbiter.sv ====
module prog_mem_arbiter (
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        boot_done,
  prog_mem_if.arbiter loader,
  prog_mem_if.arbiter seq,
  output logic        run
);
  import hack_pkg::*;

  addr_t mem_addr;
  word_t mem_wdata;
  logic  mem_we;
  word_t mem_rdata;

  // Ownership passes to the sequencer one clock after boot completes
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      run <= 1'b0;
    end else begin
      run <= boot_done;
    end
  end

  // Only the loader ever writes
  assign mem_addr  = run ? seq.addr : loader.addr;
  assign mem_wdata = loader.wdata;
  assign mem_we    = !run && loader.we;

  word_ram prog_ram (
    .CLK   (CLK),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .we    (mem_we),
    .rdata (mem_rdata)
  );

  assign loader.rdata = mem_rdata;
  assign seq.rdata    = mem_rdata;

endmodule

// ==== hw/flash_loader/flash_loader.sv ====
module flash_loader (
  input  logic          CLK,
  input  logic          rst_n,
  input  logic          miso,
  output logic          sck,
  output logic          ssb,
  output logic          mosi,
  prog_mem_if.requester mem,
  output logic          boot_done
);
  import hack_pkg::*;

  // SCK divider
  logic                                 sck_run;
  logic [$clog2(flash_half_period)-1:0] div_cnt;
  logic                                 sck_edge;
  logic                                 sck_fall;

  // Phase and frame FSMs
  logic [2:0]                          phase;
  logic [1:0]                          frame;
  logic [4:0]                          bit_cnt;
  logic                                last_bit;
  logic [$clog2(flash_reset_wait)-1:0] wait_cnt;

  // Shift registers and word assembly
  logic [31:0] frame_word;
  logic [31:0] shift_out;
  logic [7:0]  shift_in;
  logic [7:0]  high_byte;
  logic        have_high;
  addr_t       word_cnt;

  //////////////////////////////////////////////////////////////////////
  // SCK generation
  //////////////////////////////////////////////////////////////////////

  assign sck_edge = sck_run && (int'(div_cnt) == flash_half_period - 1);
  assign sck_fall = sck_edge && sck;

  // SCK parks low whenever the divider is stopped
  always_ff @(posedge CLK) begin
    if (!rst_n || !sck_run) begin
      sck     <= 1'b0;
      div_cnt <= '0;
    end else if (sck_edge) begin
      sck     <= ~sck;
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Command framing and image shift-in
  //////////////////////////////////////////////////////////////////////

  // Bits sent in the current frame, MSB first
  always_comb begin
    case (phase)
      ph_reset_1: frame_word = {flash_reset_cmd_1, 24'h0};
      ph_reset_2: frame_word = {flash_reset_cmd_2, 24'h0};
      default:    frame_word = {flash_read_cmd, flash_read_offset};
    endcase
  end

  // Command plus address is one 32-bit chunk and everything else is a byte
  assign last_bit = (phase == ph_read_cmd) ? (bit_cnt == 5'd31) : (bit_cnt == 5'd7);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      phase     <= ph_reset_1;
      frame     <= fr_select;
      ssb       <= 1'b1;
      mosi      <= 1'b0;
      sck_run   <= 1'b0;
      bit_cnt   <= '0;
      wait_cnt  <= '0;
      word_cnt  <= '0;
      have_high <= 1'b0;
      mem.we    <= 1'b0;
      boot_done <= 1'b0;
    end else begin
      // Write enable is a single-cycle pulse
      mem.we <= 1'b0;
      case (phase)
        ph_wait: begin
          // Flash needs idle time after its reset
          if (int'(wait_cnt) == flash_reset_wait - 1) begin
            wait_cnt <= '0;
            phase    <= ph_read_cmd;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        ph_done: begin
          // Image loaded and the loader parks here until reset
          boot_done <= 1'b1;
        end
        default: begin
          case (frame)
            fr_select: begin
              ssb       <= 1'b0;
              sck_run   <= 1'b1;
              bit_cnt   <= '0;
              // First bit goes out before the first rise
              mosi      <= frame_word[31];
              shift_out <= frame_word << 1;
              frame     <= fr_shift;
            end
            fr_shift: begin
              // Flash has sampled on the rise so move to the next bit
              if (sck_fall) begin
                mosi      <= shift_out[31];
                shift_out <= shift_out << 1;
                shift_in  <= {shift_in[6:0], miso};
                bit_cnt   <= bit_cnt + 1'b1;
                if (last_bit) begin
                  sck_run <= 1'b0;
                  frame   <= fr_stop;
                end
              end
            end
            fr_stop: begin
              bit_cnt <= '0;
              case (phase)
                ph_read_cmd: begin
                  // Address sent so keep ssb low and start the first byte
                  phase   <= ph_read_data;
                  sck_run <= 1'b1;
                  frame   <= fr_shift;
                end
                ph_read_data: begin
                  have_high <= ~have_high;
                  if (!have_high) begin
                    // Big-endian so the high byte arrives first
                    high_byte <= shift_in;
                    sck_run   <= 1'b1;
                    frame     <= fr_shift;
                  end else begin
                    mem.addr  <= word_cnt;
                    mem.wdata <= {high_byte, shift_in};
                    mem.we    <= 1'b1;
                    word_cnt  <= word_cnt + 1'b1;
                    if (int'(word_cnt) == boot_words - 1) begin
                      frame <= fr_unselect;
                    end else begin
                      sck_run <= 1'b1;
                      frame   <= fr_shift;
                    end
                  end
                end
                default: frame <= fr_unselect;
              endcase
            end
            fr_unselect: begin
              ssb   <= 1'b1;
              frame <= fr_select;
              case (phase)
                ph_reset_1: phase <= ph_reset_2;
                ph_reset_2: phase <= ph_wait;
                default:    phase <= ph_done;
              endcase
            end
          endcase
        end
      endcase
    end
  end

endmodule

// ==== hw/cpu/hack_cpu.sv ====
module hack_cpu (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  step,
  input  hack_pkg::hack_instr_t instruction,
  input  hack_pkg::word_t       in_m,
  output hack_pkg::word_t       out_m,
  output logic                  write_m,
  output hack_pkg::addr_t       address_m,
  output hack_pkg::addr_t       pc
);
  import hack_pkg::*;

  word_t      a_reg;
  word_t      d_reg;
  logic       is_c;
  logic [5:0] alu_ctl;
  logic [2:0] dest;
  logic [2:0] jmp;
  word_t      x;
  word_t      y;
  word_t      alu_out;
  logic       zr;
  logic       ng;
  logic       take_jump;

  //////////////////////////////////////////////////////////////////////
  // Decode and ALU
  //////////////////////////////////////////////////////////////////////

  assign is_c    = instruction.c_instr.op;
  assign alu_ctl = instruction.c_instr.alu;
  assign dest    = instruction.c_instr.dest;
  assign jmp     = instruction.c_instr.jump;

  // Hack ALU: zero and negate each input, add or and, negate result
  always_comb begin
    x = d_reg;
    y = instruction.c_instr.a ? in_m : a_reg;
    if (alu_ctl[5]) x = '0;
    if (alu_ctl[4]) x = ~x;
    if (alu_ctl[3]) y = '0;
    if (alu_ctl[2]) y = ~y;
    alu_out = alu_ctl[1] ? (x + y) : (x & y);
    if (alu_ctl[0]) alu_out = ~alu_out;
  end

  assign zr = (alu_out == '0);
  assign ng = alu_out[15];

  // lt, eq, gt against the ALU result
  assign take_jump = is_c && ((jmp[2] && ng) || (jmp[1] && zr) || (jmp[0] && !ng && !zr));

  // Memory side, sampled by the sequencer in the step cycle
  assign out_m     = alu_out;
  assign write_m   = is_c && dest[0];
  assign address_m = a_reg[14:0];

  //////////////////////////////////////////////////////////////////////
  // Register update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      a_reg <= '0;
      d_reg <= '0;
      pc    <= '0;
    end else if (step) begin
      if (!is_c) begin
        a_reg <= {1'b0, instruction.a_instr.value};
      end else begin
        if (dest[2]) a_reg <= alu_out;
        if (dest[1]) d_reg <= alu_out;
      end
      // Jump target is A as it was before this step
      pc <= take_jump ? a_reg[14:0] : pc + 1'b1;
    end
  end

endmodule

// ==== hw/cpu/cpu_sequencer.sv ====
module cpu_sequencer (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  run,
  prog_mem_if.requester         prog,
  output hack_pkg::addr_t       data_addr,
  output hack_pkg::word_t       data_wdata,
  output logic                  data_we,
  input  hack_pkg::word_t       data_rdata,
  output hack_pkg::hack_instr_t instruction,
  output hack_pkg::word_t       in_m,
  output logic                  step,
  input  hack_pkg::word_t       out_m,
  input  logic                  write_m,
  input  hack_pkg::addr_t       address_m,
  input  hack_pkg::addr_t       pc,
  output logic                  send,
  output logic [7:0]            tx_data,
  input  logic                  busy
);
  import hack_pkg::*;

  logic [3:0] state;

  // Program memory is read only from this side
  assign prog.wdata = '0;
  assign prog.we    = 1'b0;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state   <= sq_idle;
      step    <= 1'b0;
      send    <= 1'b0;
      data_we <= 1'b0;
    end else begin
      step <= 1'b0;
      send <= 1'b0;
      case (state)
        sq_idle: begin
          if (run) state <= sq_fetch;
        end
        sq_fetch: begin
          prog.addr <= pc;
          state     <= sq_operand;
        end
        sq_operand: begin
          // A is stable between steps, so address_m is the operand
          data_addr <= address_m;
          state     <= sq_instr;
        end
        sq_instr: begin
          instruction <= prog.rdata;
          state       <= sq_in_m;
        end
        sq_in_m: begin
          in_m  <= data_rdata;
          state <= sq_step;
        end
        sq_step: begin
          step  <= 1'b1;
          state <= sq_capture;
        end
        sq_capture: begin
          // CPU outputs are valid while step is high
          data_addr  <= address_m;
          data_wdata <= out_m;
          data_we    <= write_m;
          state      <= sq_write;
        end
        sq_write: begin
          data_we <= 1'b0;
          if (data_we && data_addr == tx_address) begin
            // Only the low byte goes out
            send    <= 1'b1;
            tx_data <= data_wdata[7:0];
            state   <= sq_send;
          end else begin
            state <= sq_fetch;
          end
        end
        sq_send: begin
          // busy shows up the clock after send
          state <= sq_busy;
        end
        sq_busy: begin
          if (!busy) state <= sq_fetch;
        end
        default: state <= sq_idle;
      endcase
    end
  end

endmodule

// ==== hw/uart_tx.sv ====
module uart_tx (
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       send,
  input  logic [7:0] data,
  output logic       busy,
  output logic       tx
);
  import hack_pkg::*;

  logic [$clog2(clocks_per_bit)-1:0] baud_cnt;
  logic [3:0]                        bit_cnt;
  // Data bits LSB first, then the stop bit
  logic [8:0]                        frame;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!busy) begin
      if (send) begin
        // Start bit goes out right away
        tx       <= 1'b0;
        frame    <= {1'b1, data};
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
    end else if (int'(baud_cnt) == clocks_per_bit - 1) begin
      baud_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        // Stop bit has run its full time
        busy <= 1'b0;
      end else begin
        tx      <= frame[0];
        frame   <= frame >> 1;
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

// ==== hw/board_top.sv ====
module board_top (
  input  logic CLK,
  input  logic rst_n,
  input  logic flash_miso,
  output logic flash_sck,
  output logic flash_ssb,
  output logic flash_mosi,
  output logic flash_wp_n,
  output logic flash_hold_n,
  output logic tx
);
  import hack_pkg::*;

  logic        boot_done;
  logic        run;
  addr_t       data_addr;
  word_t       data_wdata;
  logic        data_we;
  word_t       data_rdata;
  hack_instr_t instruction;
  word_t       in_m;
  logic        step;
  word_t       out_m;
  logic        write_m;
  addr_t       address_m;
  addr_t       pc;
  logic        send;
  logic [7:0]  tx_data;
  logic        busy;

  // Flash write protect and hold are unused
  assign flash_wp_n   = 1'b1;
  assign flash_hold_n = 1'b1;

  // Loader and sequencer ports into program memory
  prog_mem_if loader_mem ();
  prog_mem_if seq_mem ();

  flash_loader flash_loader_inst (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .miso      (flash_miso),
    .sck       (flash_sck),
    .ssb       (flash_ssb),
    .mosi      (flash_mosi),
    .mem       (loader_mem.requester),
    .boot_done (boot_done)
  );

  prog_mem_arbiter prog_mem_arbiter_inst (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .boot_done (boot_done),
    .loader    (loader_mem.arbiter),
    .seq       (seq_mem.arbiter),
    .run       (run)
  );

  cpu_sequencer cpu_sequencer_inst (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .run         (run),
    .prog        (seq_mem.requester),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_we     (data_we),
    .data_rdata  (data_rdata),
    .instruction (instruction),
    .in_m        (in_m),
    .step        (step),
    .out_m       (out_m),
    .write_m     (write_m),
    .address_m   (address_m),
    .pc          (pc),
    .send        (send),
    .tx_data     (tx_data),
    .busy        (busy)
  );

  hack_cpu hack_cpu_inst (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .step        (step),
    .instruction (instruction),
    .in_m        (in_m),
    .out_m       (out_m),
    .write_m     (write_m),
    .address_m   (address_m),
    .pc          (pc)
  );

  // Data memory
  word_ram data_ram (
    .CLK   (CLK),
    .addr  (data_addr),
    .wdata (data_wdata),
    .we    (data_we),
    .rdata (data_rdata)
  );

  uart_tx uart_tx_inst (
    .CLK   (CLK),
    .rst_n (rst_n),
    .send  (send),
    .data  (tx_data),
    .busy  (busy),
    .tx    (tx)
  );

endmodule

// ==== verification/board_sva.sv ====
module board_sva (
  input logic CLK,
  input logic rst_n,
  input logic sck,
  input logic ssb,
  input logic mem_we,
  input logic boot_done
);

  ///////////////////////////////////////////////////////////////////////
  // Flash pin rules
  ///////////////////////////////////////////////////////////////////////

  // SCK only moves inside a frame that was already open
  assert property (@(posedge CLK) disable iff (!rst_n)
    $changed(sck) |-> (!ssb && $past(!ssb)))
    else $error("sck toggled outside an ssb-low frame");

  // Clock parks low while deselected
  assert property (@(posedge CLK) disable iff (!rst_n) ssb |-> !sck)
    else $error("sck high while ssb high");

  ///////////////////////////////////////////////////////////////////////
  // Program memory ownership
  ///////////////////////////////////////////////////////////////////////

  assert property (@(posedge CLK) disable iff (!rst_n) boot_done |-> !mem_we)
    else $error("loader write after boot_done");

endmodule

// ==== verification/board_tb.sv ====
module board_tb;
  import hack_pkg::*;

  localparam int max_tests = 8;
  localparam int max_bytes = 16;

  logic CLK;
  logic rst_n;
  logic flash_miso;
  logic flash_sck;
  logic flash_ssb;
  logic flash_mosi;
  logic flash_wp_n;
  logic flash_hold_n;
  logic tx;

  // Test table read from the data file
  string      names [max_tests];
  word_t      images [max_tests][boot_words];
  logic [7:0] exp_bytes [max_tests][max_bytes];
  int         exp_count [max_tests];
  int         test_total;
  longint     watchdog_limit;

  // Flash model state
  word_t       image [boot_words];
  logic [31:0] mosi_shift;
  int          rise_cnt;
  int          fall_cnt;
  int          idle_cnt;
  logic [7:0]  cmd_log [$];
  int          idle_log [$];
  logic [23:0] read_addr;

  // Bytes seen on the UART line
  logic [7:0] rx_bytes [$];

  board_top board_top_inst (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .flash_miso   (flash_miso),
    .flash_sck    (flash_sck),
    .flash_ssb    (flash_ssb),
    .flash_mosi   (flash_mosi),
    .flash_wp_n   (flash_wp_n),
    .flash_hold_n (flash_hold_n),
    .tx           (tx)
  );

  bind flash_loader board_sva board_sva_inst (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .sck       (sck),
    .ssb       (ssb),
    .mem_we    (mem.we),
    .boot_done (boot_done)
  );

  always #20 CLK = ~CLK;

  ///////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ///////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic verify_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // SPI flash model
  ///////////////////////////////////////////////////////////////////////

  // Commands and address arrive MSB first on the rise
  always @(posedge flash_sck) begin
    if (!flash_ssb) begin
      mosi_shift = {mosi_shift[30:0], flash_mosi};
      rise_cnt   = rise_cnt + 1;
      if (rise_cnt == 8) cmd_log.push_back(mosi_shift[7:0]);
      if (rise_cnt == 32 && cmd_log.size() == 3) read_addr = mosi_shift[23:0];
    end
  end

  // Data bit k is put out after fall 32 + k for the next fall
  always @(negedge flash_sck) begin : flash_data_out
    int idx;
    if (!flash_ssb) begin
      fall_cnt = fall_cnt + 1;
      idx      = fall_cnt - 32;
      if (cmd_log.size() == 3 && idx >= 0 && idx < 16 * boot_words) begin
        flash_miso = image[idx / 16][15 - (idx % 16)];
      end else begin
        flash_miso = 1'b0;
      end
    end
  end

  // Start of each frame logs the idle gap before it
  always @(negedge flash_ssb) begin
    rise_cnt = 0;
    fall_cnt = 0;
    idle_log.push_back(idle_cnt);
    idle_cnt = 0;
  end

  always @(posedge CLK) begin
    if (rst_n && flash_ssb) idle_cnt = idle_cnt + 1;
  end

  // Write protect and hold stay inactive
  always @(negedge CLK) begin
    verify_level("flash_wp_n", 1'b1, flash_wp_n);
    verify_level("flash_hold_n", 1'b1, flash_hold_n);
  end

  ///////////////////////////////////////////////////////////////////////
  // UART decoder sampling mid-bit
  ///////////////////////////////////////////////////////////////////////

  always begin : uart_decode
    logic [7:0] b;
    @(negedge tx);
    repeat (clocks_per_bit / 2) @(negedge CLK);
    if (tx !== 1'b0) abort_run("UART start bit did not last half a bit time");
    for (int i = 0; i < 8; i++) begin
      repeat (clocks_per_bit) @(negedge CLK);
      b[i] = tx;
    end
    repeat (clocks_per_bit) @(negedge CLK);
    if (tx !== 1'b1) abort_run("UART stop bit missing");
    rx_bytes.push_back(b);
  end

  ///////////////////////////////////////////////////////////////////////
  // Test file, test runs and watchdog
  ///////////////////////////////////////////////////////////////////////

  task automatic load_tests();
    int    fd;
    int    code;
    string tok;
    string line;
    fd = $fopen("verification/board_tests.txt", "r");
    if (fd == 0) abort_run("could not open verification/board_tests.txt");
    test_total = 0;
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      if (tok == "#") begin
        code = $fgets(line, fd);
      end else begin
        names[test_total] = tok;
        for (int w = 0; w < boot_words; w++) begin
          code = $fscanf(fd, "%h", images[test_total][w]);
        end
        code = $fscanf(fd, "%d", exp_count[test_total]);
        for (int n = 0; n < exp_count[test_total]; n++) begin
          code = $fscanf(fd, "%h", exp_bytes[test_total][n]);
        end
        test_total++;
      end
    end
    $fclose(fd);
    if (test_total == 0) abort_run("test file holds no tests");
  endtask

  task automatic run_test(input int t);
    string n;
    n = names[t];
    image = images[t];
    @(negedge CLK);
    rst_n = 1'b0;
    cmd_log.delete();
    idle_log.delete();
    rx_bytes.delete();
    idle_cnt = 0;
    repeat (8) @(negedge CLK);
    verify_level({n, " ssb idle"}, 1'b1, flash_ssb);
    verify_level({n, " sck idle"}, 1'b0, flash_sck);
    verify_level({n, " tx idle"}, 1'b1, tx);
    rst_n = 1'b1;
    while (rx_bytes.size() < exp_count[t]) @(negedge CLK);
    // Quiet time to catch any extra byte
    repeat (20 * clocks_per_bit) @(negedge CLK);
    if (rx_bytes.size() != exp_count[t]) abort_run({n, ": wrong number of UART bytes"});
    if (cmd_log.size() != 3) abort_run({n, ": flash did not see three frames"});
    check_byte({n, " reset cmd 1"}, flash_reset_cmd_1, cmd_log[0]);
    check_byte({n, " reset cmd 2"}, flash_reset_cmd_2, cmd_log[1]);
    check_byte({n, " read cmd"}, flash_read_cmd, cmd_log[2]);
    if (idle_log[2] < flash_reset_wait) abort_run({n, ": flash reset wait too short"});
    check_word({n, " addr high"}, {8'h00, flash_read_offset[23:16]}, {8'h00, read_addr[23:16]});
    check_word({n, " addr low"}, flash_read_offset[15:0], read_addr[15:0]);
    for (int i = 0; i < exp_count[t]; i++) begin
      check_byte($sformatf("%s tx byte %0d", n, i), exp_bytes[t][i], rx_bytes[i]);
    end
  endtask

  initial begin
    longint boot_clocks;
    CLK            = 1'b0;
    rst_n          = 1'b0;
    flash_miso     = 1'b0;
    watchdog_limit = 0;
    rise_cnt       = 0;
    fall_cnt       = 0;
    idle_cnt       = 0;
    load_tests();
    // Bit times of all frames, the wait, per-byte restarts and the quiet time
    boot_clocks = (2 * 8 + 32 + 16 * boot_words) * 2 * flash_half_period
                + flash_reset_wait + 16 * (2 * boot_words + 8)
                + 20 * clocks_per_bit + 16;
    for (int t = 0; t < test_total; t++) begin
      watchdog_limit += (boot_clocks + exp_count[t] * 10 * clocks_per_bit * 2 + 2000) * 40;
    end
    for (int t = 0; t < test_total; t++) begin
      run_test(t);
    end
    $display("Simulation PASSED");
    $finish;
  end

  initial begin : watchdog
    wait (watchdog_limit > 0);
    #(watchdog_limit);
    $display("Timeout: tests did not finish in the expected time");
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== verification/board_tests.txt ====
# name, then boot_words image words (hex), then TX byte count (decimal) and TX bytes (hex)
# Image words are Hack machine code, program starts at address 0
const_out
  01A5 EC10 6001 E308 0004 EA87 0000 0000
  0000 0000 0000 0000 0000 0000 0000 0000
  1 A5
mem_alu
  0C3A EC10 0010 E308 FC10 E7D0 6001 E308
  E018 0005 E4D0 6001 E308 000D EA87 0000
  3 3B 01 FC
count_loop
  0001 EC10 6001 E308 E7D0 0006 E4D0 000D
  E302 0006 E090 0002 EA87 000D EA87 0000
  5 01 02 03 04 05
tx_burst
  6001 EFC8 EE88 EA88 0055 EC10 6001 E308
  E7C8 E348 000A EA87 0000 0000 0000 0000
  6 01 FF 00 55 56 AA

// ==== verilog.f ====
common/hack_pkg.sv
common/prog_mem_if.sv
hw/word_ram.sv
hw/prog_mem_arbiter.sv
hw/flash_loader/flash_loader.sv
hw/cpu/hack_cpu.sv
hw/cpu/cpu_sequencer.sv
hw/uart_tx.sv
hw/board_top.sv
verification/board_sva.sv
verification/board_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = board_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
